// File: src.f
trace_pkg.sv
trace_queue.sv
trace_arbiter.sv
trace_port.sv
commit_stats.sv
commit_tracer.sv
tb_commit_tracer.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the commit tracer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module tb_commit_tracer \
  -f src.f \
  -o sim_commit_tracer

# the log decides the result, so a nonzero exit of the model is tolerated here
./obj_dir/sim_commit_tracer > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed"
  exit 1
fi

if ! grep -q "PASS: all tests" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"

// File: tb_commit_tracer.sv
/*
 * testbench for the commit tracer
 * random two-port commit traffic, a credit-returning consumer and a reference model
 */
module tb_commit_tracer import trace_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WATCHDOG_NS = 400000;

  logic                               clk_i;
  logic                               rst_ni;
  commit_port_t [NR_COMMIT_PORTS-1:0] commit_i;
  priv_lvl_e                          priv_lvl_i;
  logic                               debug_mode_i;
  logic                               credit_i;
  trace_out_t                         trace_o;
  trace_stats_t                       stats_o;

  // --------------------
  // model state
  // --------------------
  trace_rec_t       exp_q [NR_COMMIT_PORTS][$];
  int               pending [$];
  int               commits [NR_COMMIT_PORTS];
  int               received [NR_COMMIT_PORTS];
  int               skipped [NR_COMMIT_PORTS];
  logic [14:0]      seq [NR_COMMIT_PORTS];
  logic [CNT_W-1:0] retired_m, traps_m;
  int               received_total, returned, cycle, errors;

  commit_tracer commit_tracer_inst (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .commit_i     ( commit_i     ),
    .priv_lvl_i   ( priv_lvl_i   ),
    .debug_mode_i ( debug_mode_i ),
    .credit_i     ( credit_i     ),
    .trace_o      ( trace_o      ),
    .stats_o      ( stats_o      )
  );

  always #20 clk_i = ~clk_i;

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp)
      else report_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
  endtask

  // classification rule of a commit
  function automatic trace_rec_t classify(input commit_port_t c, input priv_lvl_e priv,
                                          input logic dbg);
    trace_rec_t r;
    r.pc    = c.pc;
    r.insn  = c.tval;
    r.cause = c.cause;
    r.kind  = !c.ex_valid ? KIND_RETIRE : (c.cause[CAUSE_W-1] ? KIND_INTERRUPT : KIND_EXCEPTION);
    if (dbg) r.mode = MODE_D;
    else if (priv == PRIV_LVL_S) r.mode = MODE_S;
    else if (priv == PRIV_LVL_U) r.mode = MODE_U;
    else r.mode = MODE_M;
    return r;
  endfunction

  // match a received record against its port's list and skip dropped entries
  task automatic take_record(input trace_rec_t r);
    trace_rec_t e;
    int         p;
    bit         found;
    p     = int'(r.pc[0]);
    found = 1'b0;
    while (!found && exp_q[p].size() > 0) begin
      e = exp_q[p].pop_front();
      if (e.pc == r.pc) found = 1'b1;
      else skipped[p]++;
    end
    assert (found) else report_error($sformatf("record with pc %h matches no commit on port %0d",
                                               r.pc, p));
    check_value("trace_o.rec.kind", 64'(r.kind), 64'(e.kind));
    check_value("trace_o.rec.mode", 64'(r.mode), 64'(e.mode));
    check_value("trace_o.rec.insn", 64'(r.insn), 64'(e.insn));
    check_value("trace_o.rec.cause", r.cause, e.cause);
    received[p]++;
    received_total++;
    pending.push_back(cycle + $urandom_range(6));
  endtask

  // one clock cycle that drives after the rising edge and observes at the falling edge
  task automatic step_cycle(input int ack_pct, input bit credits_on, input int force_port);
    commit_port_t [NR_COMMIT_PORTS-1:0] c;
    logic [23:0]                        hi;
    int                                 n_ret, n_trap;
    @(posedge clk_i);
    #2;
    credit_i = 1'b0;
    if (credits_on && pending.size() > 0 && pending[0] <= cycle) begin
      void'(pending.pop_front());
      credit_i = 1'b1;
      returned++;
    end
    case ($urandom_range(2))
      0:       priv_lvl_i = PRIV_LVL_M;
      1:       priv_lvl_i = PRIV_LVL_S;
      default: priv_lvl_i = PRIV_LVL_U;
    endcase
    debug_mode_i = ($urandom_range(7) == 0);
    n_ret  = 0;
    n_trap = 0;
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      hi             = 24'($urandom);
      c[p].ack       = (force_port == p) || (int'($urandom_range(99)) < ack_pct);
      c[p].ex_valid  = ($urandom_range(3) == 0);
      c[p].cause     = {$urandom, $urandom};
      c[p].tval      = $urandom;
      // pc carries a per-port sequence number and the port index
      c[p].pc        = {hi, seq[p], 1'(p)};
      if (c[p].ack) begin
        exp_q[p].push_back(classify(c[p], priv_lvl_i, debug_mode_i));
        seq[p] = seq[p] + 15'd1;
        commits[p]++;
        if (c[p].ex_valid) n_trap++;
        else n_ret++;
      end
    end
    commit_i = c;
    @(negedge clk_i);
    check_value("stats_o.retired", 64'(stats_o.retired), 64'(retired_m));
    check_value("stats_o.traps", 64'(stats_o.traps), 64'(traps_m));
    retired_m = retired_m + CNT_W'(n_ret);
    traps_m   = traps_m + CNT_W'(n_trap);
    if (trace_o.valid) take_record(trace_o.rec);
    assert (received_total - returned <= int'(TRACE_CREDITS))
      else report_error("consumer holds more records than credits granted");
    cycle++;
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    report_error("simulation watchdog expired");
  end

  initial begin
    int               idle;
    int               waited;
    logic [CNT_W-1:0] drop_before [NR_COMMIT_PORTS];
    void'($urandom(32'hc83e));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    commit_i     = '0;
    priv_lvl_i   = PRIV_LVL_M;
    debug_mode_i = 1'b0;
    credit_i     = 1'b0;
    retired_m    = '0;
    traps_m      = '0;
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      commits[p]  = 0;
      received[p] = 0;
      skipped[p]  = 0;
      seq[p]      = '0;
    end
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // --------------------
    // quiet output after reset and one isolated commit
    // --------------------
    for (int i = 0; i < 10; i++) begin
      step_cycle(0, 1'b1, -1);
      assert (!trace_o.valid) else report_error("trace output valid without any commit");
    end
    step_cycle(0, 1'b1, 0);
    waited = 0;
    while (received_total == 0) begin
      assert (waited < 8) else report_error("isolated commit never reached the trace output");
      step_cycle(0, 1'b1, -1);
      waited++;
    end

    // --------------------
    // random traffic, stalled consumer, recovery
    // --------------------
    for (int i = 0; i < 1200; i++) step_cycle(40, 1'b1, -1);
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      drop_before[p] = stats_o.dropped[p];
    end
    for (int i = 0; i < 80; i++) step_cycle(70, 1'b0, -1);
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      assert (stats_o.dropped[p] != drop_before[p])
        else report_error($sformatf("port %0d counted no drop while credits were held", p));
    end
    for (int i = 0; i < 600; i++) step_cycle(30, 1'b1, -1);

    // drain until the output has been idle for a while
    idle   = 0;
    waited = 0;
    while (idle < 20 || pending.size() > 0) begin
      assert (waited < 1000) else report_error("trace output did not drain");
      step_cycle(0, 1'b1, -1);
      idle = trace_o.valid ? 0 : idle + 1;
      waited++;
    end

    // anything still listed was dropped
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      skipped[p] = skipped[p] + exp_q[p].size();
      check_value($sformatf("stats_o.dropped[%0d]", p), 64'(stats_o.dropped[p]),
                  64'(CNT_W'(skipped[p])));
      check_value($sformatf("port %0d received plus dropped", p),
                  64'(received[p] + int'(stats_o.dropped[p])), 64'(commits[p]));
    end

    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: commit_tracer.sv
/*
 * commit-side instruction tracer
 * per-port queues drained round-robin onto one credit-controlled output
 */
module commit_tracer import trace_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
  input  priv_lvl_e                          priv_lvl_i,
  input  logic                               debug_mode_i,
  input  logic                               credit_i,
  output trace_out_t                         trace_o,
  output trace_stats_t                       stats_o
);

  logic       [NR_COMMIT_PORTS-1:0] not_empty;
  trace_rec_t [NR_COMMIT_PORTS-1:0] head;
  logic       [NR_COMMIT_PORTS-1:0] pop;
  logic       [NR_COMMIT_PORTS-1:0] drop;
  logic                             credit_avail;
  logic                             send;
  trace_rec_t                       send_rec;

  // --------------------
  // per-port queues
  // --------------------
  for (genvar i = 0; i < NR_COMMIT_PORTS; i++) begin : gen_queue
    trace_queue trace_queue_inst (
      .clk_i        ( clk_i        ),
      .rst_ni       ( rst_ni       ),
      .commit_i     ( commit_i[i]  ),
      .priv_lvl_i   ( priv_lvl_i   ),
      .debug_mode_i ( debug_mode_i ),
      .pop_i        ( pop[i]       ),
      .not_empty_o  ( not_empty[i] ),
      .head_o       ( head[i]      ),
      .drop_o       ( drop[i]      )
    );
  end

  // --------------------
  // output path
  // --------------------
  trace_arbiter trace_arbiter_inst (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .not_empty_i    ( not_empty    ),
    .head_i         ( head         ),
    .credit_avail_i ( credit_avail ),
    .pop_o          ( pop          ),
    .send_o         ( send         ),
    .send_rec_o     ( send_rec     )
  );

  trace_port trace_port_inst (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .send_i         ( send         ),
    .send_rec_i     ( send_rec     ),
    .credit_i       ( credit_i     ),
    .credit_avail_o ( credit_avail ),
    .trace_o        ( trace_o      )
  );

  // statistics
  commit_stats commit_stats_inst (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .commit_i ( commit_i ),
    .drop_i   ( drop     ),
    .stats_o  ( stats_o  )
  );

endmodule

// File: commit_stats.sv
/*
 * commit statistics
 * wrapping counters for retired instructions, traps and per-port drops
 */
module commit_stats import trace_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  commit_port_t [NR_COMMIT_PORTS-1:0]   commit_i,
  input  logic         [NR_COMMIT_PORTS-1:0]   drop_i,
  output trace_stats_t                         stats_o
);

  logic [CNT_W-1:0] n_retire, n_trap;
  trace_stats_t     stats_q;

  // events this cycle over all ports
  always_comb begin
    n_retire = '0;
    n_trap   = '0;
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      n_retire = n_retire + CNT_W'(commit_i[i].ack & ~commit_i[i].ex_valid);
      n_trap   = n_trap + CNT_W'(commit_i[i].ack & commit_i[i].ex_valid);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stats_q <= '0;
    end else begin
      stats_q.retired <= stats_q.retired + n_retire;
      stats_q.traps   <= stats_q.traps + n_trap;
      for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
        if (drop_i[i]) begin
          stats_q.dropped[i] <= stats_q.dropped[i] + 1'b1;
        end
      end
    end
  end

  assign stats_o = stats_q;

endmodule

// File: trace_port.sv
/*
 * trace output port
 * keeps the consumer credit count and registers each sent record
 */
module trace_port import trace_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       send_i,
  input  trace_rec_t send_rec_i,
  input  logic       credit_i,
  output logic       credit_avail_o,
  output trace_out_t trace_o
);

  logic [CREDIT_W-1:0] credit_q;
  logic                credit_max;
  logic                valid_q;
  trace_rec_t          rec_q;

  // --------------------
  // credits
  // --------------------
  assign credit_avail_o = (credit_q != '0);
  assign credit_max     = (credit_q == CREDIT_W'(TRACE_CREDITS));

  // send and return in one cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CREDIT_W'(TRACE_CREDITS);
    end else begin
      case ({send_i, credit_i})
        2'b10: credit_q <= credit_q - 1'b1;
        2'b01: begin
          // never count past the granted amount
          if (!credit_max) begin
            credit_q <= credit_q + 1'b1;
          end
        end
        default: credit_q <= credit_q;
      endcase
    end
  end

  // --------------------
  // output register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= send_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (send_i) begin
      rec_q <= send_rec_i;
    end
  end

  assign trace_o.valid = valid_q;
  assign trace_o.rec   = rec_q;

endmodule

// File: trace_arbiter.sv
/*
 * round-robin arbiter over the trace queues
 * grants one non-empty queue per cycle while credit is available
 */
module trace_arbiter import trace_pkg::*; (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic       [NR_COMMIT_PORTS-1:0]       not_empty_i,
  input  trace_rec_t [NR_COMMIT_PORTS-1:0]       head_i,
  input  logic                                   credit_avail_i,
  output logic       [NR_COMMIT_PORTS-1:0]       pop_o,
  output logic                                   send_o,
  output trace_rec_t                             send_rec_o
);

  logic [PORT_IDX_W-1:0] rr_q;
  logic [PORT_IDX_W-1:0] winner;
  logic                  found;

  // --------------------
  // selection
  // --------------------
  // search starts at the pointer and wraps around
  always_comb begin
    winner = rr_q;
    found  = 1'b0;
    for (int off = 0; off < NR_COMMIT_PORTS; off++) begin
      if (!found && not_empty_i[(int'(rr_q) + off) % NR_COMMIT_PORTS]) begin
        winner = PORT_IDX_W'((int'(rr_q) + off) % NR_COMMIT_PORTS);
        found  = 1'b1;
      end
    end
  end

  assign send_o     = credit_avail_i & found;
  assign send_rec_o = head_i[winner];

  always_comb begin
    pop_o = '0;
    if (send_o) begin
      pop_o[winner] = 1'b1;
    end
  end

  // served port drops to lowest priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (send_o) begin
      rr_q <= PORT_IDX_W'((int'(winner) + 1) % NR_COMMIT_PORTS);
    end
  end

endmodule

// File: trace_queue.sv
/*
 * trace queue for one commit port
 * classifies each commit and buffers it, dropping it when full
 */
module trace_queue import trace_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  commit_port_t commit_i,
  input  priv_lvl_e    priv_lvl_i,
  input  logic         debug_mode_i,
  input  logic         pop_i,
  output logic         not_empty_o,
  output trace_rec_t   head_o,
  output logic         drop_o
);

  trace_rec_t             rec;
  trace_rec_t             mem_q [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [QUEUE_PTR_W:0]   cnt_q;
  logic                   full;
  logic                   push;
  logic                   pop;

  // --------------------
  // classification
  // --------------------
  always_comb begin
    rec.pc    = commit_i.pc;
    rec.insn  = commit_i.tval;
    rec.cause = commit_i.cause;

    if (!commit_i.ex_valid) begin
      rec.kind = KIND_RETIRE;
    end else if (commit_i.cause[CAUSE_W-1]) begin
      rec.kind = KIND_INTERRUPT;
    end else begin
      rec.kind = KIND_EXCEPTION;
    end

    // debug mode hides the privilege level
    if (debug_mode_i) begin
      rec.mode = MODE_D;
    end else begin
      case (priv_lvl_i)
        PRIV_LVL_S: rec.mode = MODE_S;
        PRIV_LVL_U: rec.mode = MODE_U;
        default:    rec.mode = MODE_M;
      endcase
    end
  end

  // --------------------
  // fifo control
  // --------------------
  // a full queue drops even if the head leaves this cycle
  assign full   = (cnt_q == (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
  assign push   = commit_i.ack & ~full;
  assign drop_o = commit_i.ack & full;
  assign pop    = pop_i & not_empty_o;

  assign not_empty_o = (cnt_q != '0);
  assign head_o      = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= rec;
    end
  end

endmodule

// File: trace_pkg.sv
/*
 * commit trace subsystem definitions
 * widths, depths, record encodings and the structs shared by all blocks
 */
package trace_pkg;

  // --------------------
  // sizes
  // --------------------
  localparam int unsigned NR_COMMIT_PORTS = 2;
  localparam int unsigned PC_W            = 40;
  localparam int unsigned CAUSE_W         = 64;
  localparam int unsigned INSN_W          = 32;
  localparam int unsigned QUEUE_DEPTH     = 8;
  localparam int unsigned TRACE_CREDITS   = 4;
  localparam int unsigned CNT_W           = 16;

  // derived widths
  localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned CREDIT_W    = $clog2(TRACE_CREDITS + 1);
  localparam int unsigned PORT_IDX_W  = (NR_COMMIT_PORTS > 1) ? $clog2(NR_COMMIT_PORTS) : 1;

  // --------------------
  // encodings
  // --------------------
  // risc-v privilege encoding
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  typedef enum logic [1:0] {
    MODE_M,
    MODE_S,
    MODE_U,
    MODE_D
  } trace_mode_e;

  typedef enum logic [1:0] {
    KIND_RETIRE,
    KIND_EXCEPTION,
    KIND_INTERRUPT
  } trace_kind_e;

  // --------------------
  // structs
  // --------------------
  // one commit port where ex_valid marks a trap
  typedef struct packed {
    logic               ack;
    logic [PC_W-1:0]    pc;
    logic               ex_valid;
    logic [CAUSE_W-1:0] cause;
    logic [INSN_W-1:0]  tval;
  } commit_port_t;

  typedef struct packed {
    trace_kind_e        kind;
    trace_mode_e        mode;
    logic [PC_W-1:0]    pc;
    logic [INSN_W-1:0]  insn;
    logic [CAUSE_W-1:0] cause;
  } trace_rec_t;

  typedef struct packed {
    logic       valid;
    trace_rec_t rec;
  } trace_out_t;

  typedef struct packed {
    logic [CNT_W-1:0]                      retired;
    logic [CNT_W-1:0]                      traps;
    logic [NR_COMMIT_PORTS-1:0][CNT_W-1:0] dropped;
  } trace_stats_t;

endpackage
